//--- include/id_params.svh
// Widths, major opcodes and funct codes of the decode stage
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Datapath and register index widths
`define ID_XLEN        32
`define ID_RADDR_W     5

// Major opcodes of the supported RV32I subset
`define ID_OPC_OP      7'b0110011
`define ID_OPC_OP_IMM  7'b0010011
`define ID_OPC_LUI     7'b0110111
`define ID_OPC_AUIPC   7'b0010111
`define ID_OPC_JAL     7'b1101111
`define ID_OPC_BRANCH  7'b1100011
`define ID_OPC_LOAD    7'b0000011
`define ID_OPC_STORE   7'b0100011

// ALU funct3 and the alternate funct7 for SUB/SRA
`define ID_F3_ADD      3'b000
`define ID_F3_SLL      3'b001
`define ID_F3_SLT      3'b010
`define ID_F3_SLTU     3'b011
`define ID_F3_XOR      3'b100
`define ID_F3_SR       3'b101
`define ID_F3_OR       3'b110
`define ID_F3_AND      3'b111
`define ID_F7_ALT      7'b0100000

// Branch compare funct3
`define ID_F3_BEQ      3'b000
`define ID_F3_BNE      3'b001
`define ID_F3_BLT      3'b100
`define ID_F3_BGE      3'b101
`define ID_F3_BLTU     3'b110
`define ID_F3_BGEU     3'b111

// Load/store size funct3, stores use the first three
`define ID_F3_LB       3'b000
`define ID_F3_LH       3'b001
`define ID_F3_LW       3'b010
`define ID_F3_LBU      3'b100
`define ID_F3_LHU      3'b101

`endif

//--- hdl/id_pkg.sv
// Control enums of the decode stage
// Instruction word union with one view per RV32I format
`include "id_params.svh"

package id_pkg;

  // ALU operation, compares drive the branch decision
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate used on operand B
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J,
    IMM_B_INCR_PC
  } imm_b_sel_e;

  // LSU access size, encoded as funct3[1:0] of word/half/byte reversed
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

  ////////////////////////////////
  // Instruction formats
  ////////////////////////////////

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`ID_RADDR_W-1:0] rs2;
    logic [`ID_RADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`ID_RADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]            imm11_0;
    logic [`ID_RADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`ID_RADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]             imm11_5;
    logic [`ID_RADDR_W-1:0] rs2;
    logic [`ID_RADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [4:0]             imm4_0;
    logic [6:0]             opcode;
  } s_fmt_t;

  // Scrambled branch offset, bit 0 is implicit
  typedef struct packed {
    logic                   imm12;
    logic [5:0]             imm10_5;
    logic [`ID_RADDR_W-1:0] rs2;
    logic [`ID_RADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [3:0]             imm4_1;
    logic                   imm11;
    logic [6:0]             opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]            imm31_12;
    logic [`ID_RADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                   imm20;
    logic [9:0]             imm10_1;
    logic                   imm11;
    logic [7:0]             imm19_12;
    logic [`ID_RADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } j_fmt_t;

  // Same 32 bits, read in every format
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

//--- hdl/id_dec_if.sv
// Decoded control from the decoder to the FSM and the operand mux
`timescale 1ns/1ns
`include "id_params.svh"

interface id_dec_if;

  // Sequencing and gating control
  logic lsu_req_dec;
  logic branch_in_dec;
  logic jump_in_dec;
  logic rf_we_dec;
  logic illegal_dec;

  // Operand selection
  id_pkg::op_a_sel_e  op_a_sel;
  id_pkg::op_b_sel_e  op_b_sel;
  id_pkg::imm_b_sel_e imm_b_sel;

  // Sign-extended immediates
  logic [`ID_XLEN-1:0] imm_i;
  logic [`ID_XLEN-1:0] imm_s;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_u;
  logic [`ID_XLEN-1:0] imm_j;

  modport decoder (
    output lsu_req_dec, branch_in_dec, jump_in_dec, rf_we_dec, illegal_dec,
    output op_a_sel, op_b_sel, imm_b_sel,
    output imm_i, imm_s, imm_b, imm_u, imm_j
  );

  modport fsm (
    input lsu_req_dec, branch_in_dec, jump_in_dec, rf_we_dec, illegal_dec
  );

  modport operand (
    input op_a_sel, op_b_sel, imm_b_sel,
    input imm_i, imm_s, imm_b, imm_u, imm_j
  );

endinterface

//--- hdl/id_decoder.sv
// RV32I subset decoder: opcode and funct decode, immediates,
// register addresses, LSU attributes and illegal detection
`timescale 1ns/1ns
`include "id_params.svh"

module id_decoder (
  input  id_pkg::instr_u          instr_rdata_i,
  input  logic                    instr_first_cycle_i,
  output logic [`ID_RADDR_W-1:0]  rf_raddr_a_o,
  output logic [`ID_RADDR_W-1:0]  rf_raddr_b_o,
  output logic [`ID_RADDR_W-1:0]  rf_waddr_o,
  output id_pkg::alu_op_e         alu_operator_o,
  output logic                    lsu_we_o,
  output logic                    lsu_sign_ext_o,
  output id_pkg::lsu_type_e       lsu_type_o,
  id_dec_if.decoder               dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr_rdata_i.r.opcode;
  assign funct3 = instr_rdata_i.r.funct3;
  assign funct7 = instr_rdata_i.r.funct7;

  // Register fields sit at fixed positions in every format
  assign rf_raddr_a_o = instr_rdata_i.r.rs1;
  assign rf_raddr_b_o = instr_rdata_i.r.rs2;
  assign rf_waddr_o   = instr_rdata_i.r.rd;

  ////////////////////////////////
  // Immediates
  ////////////////////////////////

  assign dec.imm_i = {{20{instr_rdata_i.i.imm11_0[11]}}, instr_rdata_i.i.imm11_0};
  assign dec.imm_s = {{20{instr_rdata_i.s.imm11_5[6]}}, instr_rdata_i.s.imm11_5,
                      instr_rdata_i.s.imm4_0};
  assign dec.imm_b = {{19{instr_rdata_i.b.imm12}}, instr_rdata_i.b.imm12,
                      instr_rdata_i.b.imm11, instr_rdata_i.b.imm10_5,
                      instr_rdata_i.b.imm4_1, 1'b0};
  assign dec.imm_u = {instr_rdata_i.u.imm31_12, 12'b0};
  assign dec.imm_j = {{11{instr_rdata_i.j.imm20}}, instr_rdata_i.j.imm20,
                      instr_rdata_i.j.imm19_12, instr_rdata_i.j.imm11,
                      instr_rdata_i.j.imm10_1, 1'b0};

  ////////////////////////////////
  // Control decode
  ////////////////////////////////

  always_comb begin
    // Defaults: register-register add, no side effects
    dec.lsu_req_dec   = 1'b0;
    dec.branch_in_dec = 1'b0;
    dec.jump_in_dec   = 1'b0;
    dec.rf_we_dec     = 1'b0;
    dec.illegal_dec   = 1'b0;
    dec.op_a_sel      = id_pkg::OP_A_REG_A;
    dec.op_b_sel      = id_pkg::OP_B_REG_B;
    dec.imm_b_sel     = id_pkg::IMM_B_I;
    alu_operator_o    = id_pkg::ALU_ADD;
    lsu_we_o          = 1'b0;
    lsu_sign_ext_o    = 1'b0;
    lsu_type_o        = id_pkg::LSU_WORD;

    case (opcode)
      `ID_OPC_OP: begin
        dec.rf_we_dec = 1'b1;
        case ({funct7, funct3})
          {7'b0, `ID_F3_ADD}:       alu_operator_o = id_pkg::ALU_ADD;
          {`ID_F7_ALT, `ID_F3_ADD}: alu_operator_o = id_pkg::ALU_SUB;
          {7'b0, `ID_F3_SLL}:       alu_operator_o = id_pkg::ALU_SLL;
          {7'b0, `ID_F3_SLT}:       alu_operator_o = id_pkg::ALU_SLT;
          {7'b0, `ID_F3_SLTU}:      alu_operator_o = id_pkg::ALU_SLTU;
          {7'b0, `ID_F3_XOR}:       alu_operator_o = id_pkg::ALU_XOR;
          {7'b0, `ID_F3_SR}:        alu_operator_o = id_pkg::ALU_SRL;
          {`ID_F7_ALT, `ID_F3_SR}:  alu_operator_o = id_pkg::ALU_SRA;
          {7'b0, `ID_F3_OR}:        alu_operator_o = id_pkg::ALU_OR;
          {7'b0, `ID_F3_AND}:       alu_operator_o = id_pkg::ALU_AND;
          default:                  dec.illegal_dec = 1'b1;
        endcase
      end

      `ID_OPC_OP_IMM: begin
        dec.rf_we_dec = 1'b1;
        dec.op_b_sel  = id_pkg::OP_B_IMM;
        case (funct3)
          `ID_F3_ADD:  alu_operator_o = id_pkg::ALU_ADD;
          `ID_F3_SLT:  alu_operator_o = id_pkg::ALU_SLT;
          `ID_F3_SLTU: alu_operator_o = id_pkg::ALU_SLTU;
          `ID_F3_XOR:  alu_operator_o = id_pkg::ALU_XOR;
          `ID_F3_OR:   alu_operator_o = id_pkg::ALU_OR;
          `ID_F3_AND:  alu_operator_o = id_pkg::ALU_AND;
          `ID_F3_SLL: begin
            alu_operator_o  = id_pkg::ALU_SLL;
            dec.illegal_dec = (funct7 != 7'b0);
          end
          default: begin
            // Shift right, imm[10] picks arithmetic
            alu_operator_o  = (funct7 == `ID_F7_ALT) ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
            dec.illegal_dec = (funct7 != 7'b0) && (funct7 != `ID_F7_ALT);
          end
        endcase
      end

      `ID_OPC_LUI: begin
        dec.rf_we_dec = 1'b1;
        dec.op_a_sel  = id_pkg::OP_A_ZERO;
        dec.op_b_sel  = id_pkg::OP_B_IMM;
        dec.imm_b_sel = id_pkg::IMM_B_U;
      end

      `ID_OPC_AUIPC: begin
        dec.rf_we_dec = 1'b1;
        dec.op_a_sel  = id_pkg::OP_A_CURRPC;
        dec.op_b_sel  = id_pkg::OP_B_IMM;
        dec.imm_b_sel = id_pkg::IMM_B_U;
      end

      `ID_OPC_JAL: begin
        // Target first, then the link value PC + 4
        dec.jump_in_dec = 1'b1;
        dec.rf_we_dec   = 1'b1;
        dec.op_a_sel    = id_pkg::OP_A_CURRPC;
        dec.op_b_sel    = id_pkg::OP_B_IMM;
        dec.imm_b_sel   = instr_first_cycle_i ? id_pkg::IMM_B_J : id_pkg::IMM_B_INCR_PC;
      end

      `ID_OPC_BRANCH: begin
        dec.branch_in_dec = 1'b1;
        if (instr_first_cycle_i) begin
          // Condition from a register compare
          case (funct3)
            `ID_F3_BEQ:  alu_operator_o = id_pkg::ALU_EQ;
            `ID_F3_BNE:  alu_operator_o = id_pkg::ALU_NE;
            `ID_F3_BLT:  alu_operator_o = id_pkg::ALU_LT;
            `ID_F3_BGE:  alu_operator_o = id_pkg::ALU_GE;
            `ID_F3_BLTU: alu_operator_o = id_pkg::ALU_LTU;
            `ID_F3_BGEU: alu_operator_o = id_pkg::ALU_GEU;
            default:     dec.illegal_dec = 1'b1;
          endcase
        end else begin
          // Target cycle, PC plus B offset
          dec.op_a_sel  = id_pkg::OP_A_CURRPC;
          dec.op_b_sel  = id_pkg::OP_B_IMM;
          dec.imm_b_sel = id_pkg::IMM_B_B;
        end
      end

      `ID_OPC_LOAD: begin
        dec.lsu_req_dec = 1'b1;
        dec.rf_we_dec   = 1'b1;
        dec.op_b_sel    = id_pkg::OP_B_IMM;
        lsu_sign_ext_o  = ~funct3[2];
        case (funct3)
          `ID_F3_LB, `ID_F3_LBU: lsu_type_o = id_pkg::LSU_BYTE;
          `ID_F3_LH, `ID_F3_LHU: lsu_type_o = id_pkg::LSU_HALF;
          `ID_F3_LW:             lsu_type_o = id_pkg::LSU_WORD;
          default:               dec.illegal_dec = 1'b1;
        endcase
      end

      `ID_OPC_STORE: begin
        dec.lsu_req_dec = 1'b1;
        dec.op_b_sel    = id_pkg::OP_B_IMM;
        dec.imm_b_sel   = id_pkg::IMM_B_S;
        lsu_we_o        = 1'b1;
        case (funct3)
          `ID_F3_LB: lsu_type_o = id_pkg::LSU_BYTE;
          `ID_F3_LH: lsu_type_o = id_pkg::LSU_HALF;
          `ID_F3_LW: lsu_type_o = id_pkg::LSU_WORD;
          default:   dec.illegal_dec = 1'b1;
        endcase
      end

      default: dec.illegal_dec = 1'b1;
    endcase
  end

endmodule

//--- hdl/id_operand_mux.sv
// ALU operand selection and the immediate mux for operand B
`timescale 1ns/1ns
`include "id_params.svh"

module id_operand_mux (
  input  logic [`ID_XLEN-1:0] pc_id_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0] rf_rdata_b_i,
  id_dec_if.operand           opr,
  output logic [`ID_XLEN-1:0] alu_operand_a_o,
  output logic [`ID_XLEN-1:0] alu_operand_b_o
);

  logic [`ID_XLEN-1:0] imm_b;

  ////////////////////////////////
  // Immediate for operand B
  ////////////////////////////////

  always_comb begin
    case (opr.imm_b_sel)
      id_pkg::IMM_B_I:       imm_b = opr.imm_i;
      id_pkg::IMM_B_S:       imm_b = opr.imm_s;
      id_pkg::IMM_B_B:       imm_b = opr.imm_b;
      id_pkg::IMM_B_U:       imm_b = opr.imm_u;
      id_pkg::IMM_B_J:       imm_b = opr.imm_j;
      // Link value, no compressed instructions
      default:               imm_b = `ID_XLEN'd4;
    endcase
  end

  // Operand A: register, current PC or zero for LUI
  always_comb begin
    case (opr.op_a_sel)
      id_pkg::OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      id_pkg::OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:             alu_operand_a_o = '0;
    endcase
  end

  // Operand B: register or immediate
  assign alu_operand_b_o = (opr.op_b_sel == id_pkg::OP_B_IMM) ? imm_b : rf_rdata_b_i;

endmodule

//--- hdl/id_exec_fsm.sv
// First/multi-cycle execute FSM with stall generation,
// registered branch set and write/request gating
`timescale 1ns/1ns

module id_exec_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,
  id_dec_if.fsm ctl,
  output logic instr_first_cycle_o,
  output logic rf_we_o,
  output logic lsu_req_o,
  output logic pc_set_o,
  output logic instr_done_o
);

  typedef enum logic { FIRST_CYCLE, MULTI_CYCLE } id_fsm_e;

  id_fsm_e state_q, state_d;
  logic    branch_set_q, branch_set_d;
  logic    jump_set;
  logic    stall_mem, stall_branch, stall_jump;
  logic    legal_valid;

  assign legal_valid         = instr_valid_i & ~ctl.illegal_dec;
  assign instr_first_cycle_o = instr_valid_i & (state_q == FIRST_CYCLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      branch_set_q <= branch_set_d;
    end
  end

  ////////////////////////////////
  // Next state and stalls
  ////////////////////////////////

  always_comb begin
    state_d      = state_q;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;
    stall_mem    = 1'b0;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;

    // Illegal instructions complete at once
    if (legal_valid) begin
      case (state_q)
        FIRST_CYCLE: begin
          case (1'b1)
            ctl.lsu_req_dec: begin
              // Request now, response at the earliest next cycle
              state_d   = MULTI_CYCLE;
              stall_mem = 1'b1;
            end
            ctl.branch_in_dec: begin
              // Taken branch computes its target next cycle
              state_d      = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
              stall_branch = branch_decision_i;
              branch_set_d = branch_decision_i;
            end
            ctl.jump_in_dec: begin
              state_d    = MULTI_CYCLE;
              stall_jump = 1'b1;
              jump_set   = 1'b1;
            end
            default: state_d = FIRST_CYCLE;
          endcase
        end
        MULTI_CYCLE: begin
          // Hold until the LSU answers, branch and jump finish here
          if (ctl.lsu_req_dec && !lsu_resp_valid_i) begin
            stall_mem = 1'b1;
          end else begin
            state_d = FIRST_CYCLE;
          end
        end
        default: state_d = FIRST_CYCLE;
      endcase
    end
  end

  ////////////////////////////////
  // Output gating
  ////////////////////////////////

  assign instr_done_o = instr_valid_i & ~(stall_mem | stall_branch | stall_jump);

  // Write only on completion, so a jump's first cycle never writes
  assign rf_we_o   = instr_done_o & ctl.rf_we_dec & ~ctl.illegal_dec;
  assign lsu_req_o = legal_valid & (state_q == FIRST_CYCLE) & ctl.lsu_req_dec;

  // Jump sets in cycle 1, a taken branch from the register in cycle 2
  assign pc_set_o  = instr_valid_i & (jump_set | branch_set_q);

endmodule

//--- hdl/id_stage.sv
// Decode and execute-control stage top level
// Decoder, execute FSM and operand mux joined by the decode interface
`timescale 1ns/1ns
`include "id_params.svh"

module id_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Fetch register
  input  logic                    instr_valid_i,
  input  logic [31:0]             instr_rdata_i,
  input  logic [`ID_XLEN-1:0]     pc_id_i,

  // Execute feedback
  input  logic                    branch_decision_i,
  input  logic                    lsu_resp_valid_i,

  // Register file read data
  input  logic [`ID_XLEN-1:0]     rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]     rf_rdata_b_i,

  output logic                    illegal_insn_o,

  // Register file addresses and write enable
  output logic [`ID_RADDR_W-1:0]  rf_raddr_a_o,
  output logic [`ID_RADDR_W-1:0]  rf_raddr_b_o,
  output logic [`ID_RADDR_W-1:0]  rf_waddr_o,
  output logic                    rf_we_o,

  // ALU
  output id_pkg::alu_op_e         alu_operator_o,
  output logic [`ID_XLEN-1:0]     alu_operand_a_o,
  output logic [`ID_XLEN-1:0]     alu_operand_b_o,

  // LSU
  output logic                    lsu_req_o,
  output logic                    lsu_we_o,
  output id_pkg::lsu_type_e       lsu_type_o,
  output logic                    lsu_sign_ext_o,
  output logic [`ID_XLEN-1:0]     lsu_wdata_o,

  // Fetch control and retire
  output logic                    pc_set_o,
  output logic                    instr_done_o
);

  id_pkg::instr_u instr;
  logic           instr_first_cycle;

  id_dec_if dec_if ();

  // One word, decoded through every format view
  assign instr = id_pkg::instr_u'(instr_rdata_i);

  id_decoder u_decoder (
    .instr_rdata_i       (instr),
    .instr_first_cycle_i (instr_first_cycle),
    .rf_raddr_a_o        (rf_raddr_a_o),
    .rf_raddr_b_o        (rf_raddr_b_o),
    .rf_waddr_o          (rf_waddr_o),
    .alu_operator_o      (alu_operator_o),
    .lsu_we_o            (lsu_we_o),
    .lsu_sign_ext_o      (lsu_sign_ext_o),
    .lsu_type_o          (lsu_type_o),
    .dec                 (dec_if.decoder)
  );

  id_operand_mux u_operand_mux (
    .pc_id_i         (pc_id_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .opr             (dec_if.operand),
    .alu_operand_a_o (alu_operand_a_o),
    .alu_operand_b_o (alu_operand_b_o)
  );

  id_exec_fsm u_exec_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_valid_i),
    .branch_decision_i   (branch_decision_i),
    .lsu_resp_valid_i    (lsu_resp_valid_i),
    .ctl                 (dec_if.fsm),
    .instr_first_cycle_o (instr_first_cycle),
    .rf_we_o             (rf_we_o),
    .lsu_req_o           (lsu_req_o),
    .pc_set_o            (pc_set_o),
    .instr_done_o        (instr_done_o)
  );

  // Store data comes straight from register B
  assign lsu_wdata_o    = rf_rdata_b_i;
  assign illegal_insn_o = instr_valid_i & dec_if.illegal_dec;

endmodule

//--- dv/id_stage_assert.sv
// Concurrent checks on the execute FSM strobes
// Bound into every id_stage instance
`timescale 1ns/1ns

module id_stage_assert (
  input logic clk_i,
  input logic rst_ni,
  input logic instr_valid_i,
  input logic instr_done_i,
  input logic illegal_insn_i,
  input logic rf_we_i,
  input logic lsu_req_i,
  input logic pc_set_i
);

  // At most one redirect per instruction and never back to back
  pc_set_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_i |=> !pc_set_i)
    else $error("pc_set_o high in two consecutive cycles");

  // Illegal instructions leave no side effects
  illegal_quiet : assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_i |-> (!rf_we_i && !lsu_req_i))
    else $error("illegal instruction raised rf_we_o or lsu_req_o");

  // Memory request only in an instruction's first cycle
  // which follows an idle cycle or a completion
  req_first_only : assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_i |-> (!$past(instr_valid_i) || $past(instr_done_i)))
    else $error("lsu_req_o high outside the first cycle");

endmodule

bind id_stage id_stage_assert u_id_stage_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .instr_valid_i  (instr_valid_i),
  .instr_done_i   (instr_done_o),
  .illegal_insn_i (illegal_insn_o),
  .rf_we_i        (rf_we_o),
  .lsu_req_i      (lsu_req_o),
  .pc_set_i       (pc_set_o)
);

//--- dv/id_stage_tb.sv
// Testbench for the decode and execute-control stage
// Stimulus table, LCG register data, typed compare tasks and cycle timeout
`timescale 1ns/1ns
`include "id_params.svh"

module id_stage_tb;

  localparam int NUM_TESTS = 19;
  localparam int MAX_DELAY = 4;
  // Reset, one spare cycle, then the worst case per entry
  localparam int LIMIT     = 8 + 2 + NUM_TESTS * (MAX_DELAY + 4);

  typedef struct packed {
    logic [31:0]     instr;
    logic [31:0]     pc;
    logic            taken;
    int              delay;
    id_pkg::alu_op_e op;
    logic            we;
    int              cycles;
  } entry_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   instr_valid_i;
  logic [31:0]            instr_rdata_i;
  logic [`ID_XLEN-1:0]    pc_id_i;
  logic                   branch_decision_i;
  logic                   lsu_resp_valid_i;
  logic [`ID_XLEN-1:0]    rf_rdata_a_i;
  logic [`ID_XLEN-1:0]    rf_rdata_b_i;
  logic                   illegal_insn_o;
  logic [`ID_RADDR_W-1:0] rf_raddr_a_o;
  logic [`ID_RADDR_W-1:0] rf_raddr_b_o;
  logic [`ID_RADDR_W-1:0] rf_waddr_o;
  logic                   rf_we_o;
  id_pkg::alu_op_e        alu_operator_o;
  logic [`ID_XLEN-1:0]    alu_operand_a_o;
  logic [`ID_XLEN-1:0]    alu_operand_b_o;
  logic                   lsu_req_o;
  logic                   lsu_we_o;
  id_pkg::lsu_type_e      lsu_type_o;
  logic                   lsu_sign_ext_o;
  logic [`ID_XLEN-1:0]    lsu_wdata_o;
  logic                   pc_set_o;
  logic                   instr_done_o;

  entry_t      tbl [NUM_TESTS];
  logic [31:0] lcg_state = 32'd79480;
  int          cycle_cnt = 0;
  int          err_cnt   = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;

  id_stage u_id_stage (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  ///////////////////////////////
  // Helpers
  ///////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic opcode_known(input logic [6:0] opc);
    case (opc)
      `ID_OPC_OP, `ID_OPC_OP_IMM, `ID_OPC_LUI, `ID_OPC_AUIPC,
      `ID_OPC_JAL, `ID_OPC_BRANCH, `ID_OPC_LOAD, `ID_OPC_STORE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_word(input string name, input logic [`ID_XLEN-1:0] got,
                            input logic [`ID_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_reg(input string name, input logic [`ID_RADDR_W-1:0] got,
                           input logic [`ID_RADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_op(input string name, input id_pkg::alu_op_e got,
                          input id_pkg::alu_op_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %s expected %s", $time, name, got.name(),
               exp.name());
      err_cnt++;
    end
  endtask

  task automatic check_type(input string name, input id_pkg::lsu_type_e got,
                            input id_pkg::lsu_type_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %s expected %s", $time, name, got.name(),
               exp.name());
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  ///////////////////////////////
  // Stimulus table
  ///////////////////////////////

  task automatic load_table();
    // instr, pc, taken, lsu delay, operator, writes, done cycle
    tbl[0]  = '{32'h002081B3, 32'h00001000, 1'b0, 0, id_pkg::ALU_ADD, 1'b1, 1}; // add
    tbl[1]  = '{32'h407302B3, 32'h00001004, 1'b0, 0, id_pkg::ALU_SUB, 1'b1, 1}; // sub
    tbl[2]  = '{32'hFF448213, 32'h00001008, 1'b0, 0, id_pkg::ALU_ADD, 1'b1, 1}; // addi
    tbl[3]  = '{32'h5A55C513, 32'h0000100C, 1'b0, 0, id_pkg::ALU_XOR, 1'b1, 1}; // xori
    tbl[4]  = '{32'h4076D613, 32'h00001010, 1'b0, 0, id_pkg::ALU_SRA, 1'b1, 1}; // srai
    tbl[5]  = '{32'hABCDE3B7, 32'h00001014, 1'b0, 0, id_pkg::ALU_ADD, 1'b1, 1}; // lui
    tbl[6]  = '{32'h12345417, 32'h80002018, 1'b0, 0, id_pkg::ALU_ADD, 1'b1, 1}; // auipc
    tbl[7]  = '{32'hFF87A703, 32'h0000201C, 1'b0, 1, id_pkg::ALU_ADD, 1'b1, 2}; // lw
    tbl[8]  = '{32'h0038C803, 32'h00002020, 1'b0, 3, id_pkg::ALU_ADD, 1'b1, 4}; // lbu
    tbl[9]  = '{32'h01099903, 32'h00002024, 1'b0, 2, id_pkg::ALU_ADD, 1'b1, 3}; // lh
    tbl[10] = '{32'h034AA223, 32'h00002028, 1'b0, 4, id_pkg::ALU_ADD, 1'b0, 5}; // sw
    tbl[11] = '{32'hFF6B8FA3, 32'h0000202C, 1'b0, 2, id_pkg::ALU_ADD, 1'b0, 3}; // sb
    tbl[12] = '{32'h00208863, 32'h00003000, 1'b0, 0, id_pkg::ALU_EQ,  1'b0, 1}; // beq
    tbl[13] = '{32'hFE4190E3, 32'h00003004, 1'b1, 0, id_pkg::ALU_NE,  1'b0, 2}; // bne
    tbl[14] = '{32'h1062E063, 32'h00003008, 1'b1, 0, id_pkg::ALU_LTU, 1'b0, 2}; // bltu
    tbl[15] = '{32'h001000EF, 32'h0000300C, 1'b0, 0, id_pkg::ALU_ADD, 1'b1, 2}; // jal +
    tbl[16] = '{32'hFFDFF2EF, 32'h00003010, 1'b0, 0, id_pkg::ALU_ADD, 1'b1, 2}; // jal -
    tbl[17] = '{32'h00000073, 32'h00003014, 1'b0, 0, id_pkg::ALU_ADD, 1'b0, 1}; // system
    tbl[18] = '{32'hFFFFFFFF, 32'h00003018, 1'b0, 0, id_pkg::ALU_ADD, 1'b0, 1}; // all ones
  endtask

  ///////////////////////////////
  // One table entry
  ///////////////////////////////

  task automatic run_entry(input int idx);
    entry_t              e;
    id_pkg::instr_u      iw;
    logic [6:0]          opc;
    logic [31:0]         w;
    logic [`ID_XLEN-1:0] ra, rb, imm_i, imm_s, imm_b, imm_u, imm_j, exp_a, exp_b;
    logic                is_mem, is_ill;
    id_pkg::lsu_type_e   exp_type;
    int                  cyc;
    int                  errs_before;
    e           = tbl[idx];
    w           = e.instr;
    iw          = id_pkg::instr_u'(e.instr);
    opc         = iw.r.opcode;
    is_ill      = !opcode_known(opc);
    is_mem      = (opc == `ID_OPC_LOAD) || (opc == `ID_OPC_STORE);
    ra          = lcg_next();
    rb          = lcg_next();
    errs_before = err_cnt;
    // Immediates straight from the RV32I bit layout
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    case (iw.r.funct3[1:0])
      2'b00:   exp_type = id_pkg::LSU_BYTE;
      2'b01:   exp_type = id_pkg::LSU_HALF;
      default: exp_type = id_pkg::LSU_WORD;
    endcase

    // Every strobe stays low in the idle cycle
    @(posedge clk_i);
    #10;
    instr_valid_i     = 1'b0;
    lsu_resp_valid_i  = 1'b0;
    branch_decision_i = 1'b0;
    @(negedge clk_i);
    check_bit("pc_set_o idle", pc_set_o, 1'b0);
    check_bit("lsu_req_o idle", lsu_req_o, 1'b0);
    check_bit("rf_we_o idle", rf_we_o, 1'b0);
    check_bit("instr_done_o idle", instr_done_o, 1'b0);

    for (cyc = 1; cyc <= e.cycles; cyc++) begin
      @(posedge clk_i);
      #10;
      instr_valid_i     = 1'b1;
      instr_rdata_i     = e.instr;
      pc_id_i           = e.pc;
      rf_rdata_a_i      = ra;
      rf_rdata_b_i      = rb;
      branch_decision_i = e.taken;
      lsu_resp_valid_i  = is_mem && (cyc == 1 + e.delay);
      @(negedge clk_i);

      // Completion and strobes
      check_bit("instr_done_o", instr_done_o, cyc == e.cycles);
      check_bit("rf_we_o", rf_we_o, (cyc == e.cycles) && e.we);
      check_bit("lsu_req_o", lsu_req_o, is_mem && (cyc == 1));
      check_bit("pc_set_o", pc_set_o, ((opc == `ID_OPC_JAL) && (cyc == 1)) ||
                ((opc == `ID_OPC_BRANCH) && e.taken && (cyc == 2)));
      check_bit("illegal_insn_o", illegal_insn_o, is_ill);

      if (!is_ill) begin
        case (opc)
          `ID_OPC_OP: begin
            exp_a = ra;
            exp_b = rb;
          end
          `ID_OPC_STORE: begin
            exp_a = ra;
            exp_b = imm_s;
          end
          `ID_OPC_LUI: begin
            exp_a = '0;
            exp_b = imm_u;
          end
          `ID_OPC_AUIPC: begin
            exp_a = e.pc;
            exp_b = imm_u;
          end
          `ID_OPC_BRANCH: begin
            exp_a = (cyc == 1) ? ra : e.pc;
            exp_b = (cyc == 1) ? rb : imm_b;
          end
          `ID_OPC_JAL: begin
            exp_a = e.pc;
            exp_b = (cyc == 1) ? imm_j : `ID_XLEN'd4;
          end
          // OP-IMM and loads
          default: begin
            exp_a = ra;
            exp_b = imm_i;
          end
        endcase
        check_word("alu_operand_a_o", alu_operand_a_o, exp_a);
        check_word("alu_operand_b_o", alu_operand_b_o, exp_b);
        check_op("alu_operator_o", alu_operator_o,
                 ((opc == `ID_OPC_BRANCH) && (cyc > 1)) ? id_pkg::ALU_ADD : e.op);
        if (e.we) check_reg("rf_waddr_o", rf_waddr_o, iw.r.rd);
        if ((opc != `ID_OPC_LUI) && (opc != `ID_OPC_AUIPC) && (opc != `ID_OPC_JAL))
          check_reg("rf_raddr_a_o", rf_raddr_a_o, iw.r.rs1);
        if ((opc == `ID_OPC_OP) || (opc == `ID_OPC_BRANCH) || (opc == `ID_OPC_STORE))
          check_reg("rf_raddr_b_o", rf_raddr_b_o, iw.r.rs2);
      end

      // LSU attributes follow funct3
      if (is_mem && (cyc == 1)) begin
        check_bit("lsu_we_o", lsu_we_o, opc == `ID_OPC_STORE);
        check_type("lsu_type_o", lsu_type_o, exp_type);
        check_bit("lsu_sign_ext_o", lsu_sign_ext_o,
                  (opc == `ID_OPC_LOAD) && !iw.r.funct3[2]);
        check_word("lsu_wdata_o", lsu_wdata_o, rb);
      end

      if (instr_done_o) break;
    end

    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("test %0d instr %h: ok after %0d cycles", idx, e.instr, cyc);
    end else begin
      fail_cnt++;
      $display("test %0d instr %h: %0d mismatches", idx, e.instr, err_cnt - errs_before);
    end
  endtask

  ///////////////////////////////
  // Main sequence
  ///////////////////////////////

  initial begin
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    branch_decision_i = 1'b0;
    lsu_resp_valid_i  = 1'b0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    load_table();
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end

    $display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Runaway guard, sized from the table
  initial begin
    wait (cycle_cnt >= LIMIT);
    $display("Timeout after %0d cycles, the table did not complete", cycle_cnt);
    $display("Test failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+include
hdl/id_pkg.sv
hdl/id_dec_if.sv
hdl/id_decoder.sv
hdl/id_operand_mux.sv
hdl/id_exec_fsm.sv
hdl/id_stage.sv
dv/id_stage_assert.sv
dv/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the id_stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module id_stage_tb -o id_stage_sim &&
./obj_dir/id_stage_sim > sim.log 2>&1
status=$?
cat sim.log 2>/dev/null
[ "$status" -eq 0 ] && ! grep -q "Test failed" sim.log || { echo "Simulation FAILED"; exit 1; }
exit 0
